//--- flist.f
+incdir+hw
hw/ooo_pkg.sv
hw/arch_regfile.sv
hw/rob.sv
hw/exec_pipe.sv
hw/dispatch_unit.sv
hw/ooo_core_top.sv
testbench/ooo_assertions.sv
testbench/tb_ooo_core.sv

//--- hw/arch_regfile.sv
`include "ooo_settings.svh"

module arch_regfile
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,

    // combinational operand reads
    input  reg_idx_t         rs1_addr_i,
    input  reg_idx_t         rs2_addr_i,
    output logic [`XLEN-1:0] rs1_data_o,
    output logic [`XLEN-1:0] rs2_data_o,

    // retirement write
    input  logic             wr_en_i,
    input  reg_idx_t         wr_addr_i,
    input  logic [`XLEN-1:0] wr_data_i
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 is hardwired to zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

//--- hw/dispatch_unit.sv
`include "ooo_settings.svh"

module dispatch_unit
    import ooo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // instruction input
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  op_e                   in_op_i,
    input  reg_idx_t              in_rd_i,
    input  reg_idx_t              in_rs1_i,
    input  reg_idx_t              in_rs2_i,
    input  logic [`XLEN-1:0]      in_imm_i,

    // operand read from the register file
    output reg_idx_t              rs1_addr_o,
    output reg_idx_t              rs2_addr_o,
    input  logic [`XLEN-1:0]      rs1_data_i,
    input  logic [`XLEN-1:0]      rs2_data_i,

    // ROB allocation
    input  logic                  rob_full_i,
    input  logic [`ROB_TAG_W-1:0] rob_tail_i,
    output logic                  enq_o,
    output rob_entry_t            enq_entry_o,

    // issue to the execution pipe
    output logic                  issue_valid_o,
    output op_e                   issue_op_o,
    output logic [`XLEN-1:0]      issue_a_o,
    output logic [`XLEN-1:0]      issue_b_o,
    output logic [`ROB_TAG_W-1:0] issue_tag_o,

    // retirement feedback
    input  logic                  commit_valid_i,
    input  reg_idx_t              commit_rd_i
);

    // one bit per register with an uncommitted producer
    logic [`NUM_REGS-1:0] busy;

    logic uses_rs2;
    logic accept;

    // addi takes its second operand from the immediate
    assign uses_rs2 = (in_op_i != op_addi);

    // stall on any pending producer of a source or of rd
    assign in_ready_o = !rob_full_i
                     && !busy[in_rs1_i]
                     && !(uses_rs2 && busy[in_rs2_i])
                     && !busy[in_rd_i];

    assign accept = in_valid_i && in_ready_o;

    assign rs1_addr_o = in_rs1_i;
    assign rs2_addr_o = in_rs2_i;

    always_comb begin
        enq_o       = accept;
        enq_entry_o = '{valid: 1'b1, status: st_wait, rd: in_rd_i, data: '0};
    end

    always_comb begin
        issue_valid_o = accept;
        issue_op_o    = in_op_i;
        issue_a_o     = rs1_data_i;
        issue_b_o     = uses_rs2 ? rs2_data_i : in_imm_i;
        // the tail slot becomes the tag of this instruction
        issue_tag_o   = rob_tail_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (commit_valid_i) begin
                busy[commit_rd_i] <= 1'b0;
            end
            // a new claim on the same register wins over the clear
            if (accept && (in_rd_i != '0)) begin
                busy[in_rd_i] <= 1'b1;
            end
        end
    end

endmodule

//--- hw/exec_pipe.sv
`include "ooo_settings.svh"

module exec_pipe
    import ooo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // issue from dispatch, always accepted
    input  logic                  issue_valid_i,
    input  op_e                   issue_op_i,
    input  logic [`XLEN-1:0]      issue_a_i,
    input  logic [`XLEN-1:0]      issue_b_i,
    input  logic [`ROB_TAG_W-1:0] issue_tag_i,

    // single-cycle path result
    output logic                  alu_wb_valid_o,
    output logic [`ROB_TAG_W-1:0] alu_wb_tag_o,
    output logic [`XLEN-1:0]      alu_wb_data_o,

    // multiplier result
    output logic                  mul_wb_valid_o,
    output logic [`ROB_TAG_W-1:0] mul_wb_tag_o,
    output logic [`XLEN-1:0]      mul_wb_data_o
);

    logic [`XLEN-1:0]      alu_result;
    logic [`XLEN-1:0]      mul_product;

    logic                  alu_valid_q;
    logic [`ROB_TAG_W-1:0] alu_tag_q;
    logic [`XLEN-1:0]      alu_data_q;

    // one slot per multiplier stage, several multiplies may be in flight
    logic [`MUL_STAGES-1:0] mul_valid_q;
    logic [`ROB_TAG_W-1:0]  mul_tag_q  [`MUL_STAGES];
    logic [`XLEN-1:0]       mul_data_q [`MUL_STAGES];

    // addi and add share the adder
    always_comb begin
        case (issue_op_i)
            op_xor:  alu_result = issue_a_i ^ issue_b_i;
            default: alu_result = issue_a_i + issue_b_i;
        endcase
    end

    // only the low word of the product is kept
    assign mul_product = issue_a_i * issue_b_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= '0;
        end else begin
            alu_valid_q    <= issue_valid_i && (issue_op_i != op_mul);
            mul_valid_q[0] <= issue_valid_i && (issue_op_i == op_mul);
            for (int i = 1; i < `MUL_STAGES; i++) begin
                mul_valid_q[i] <= mul_valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        alu_tag_q     <= issue_tag_i;
        alu_data_q    <= alu_result;
        mul_tag_q[0]  <= issue_tag_i;
        mul_data_q[0] <= mul_product;
        for (int i = 1; i < `MUL_STAGES; i++) begin
            mul_tag_q[i]  <= mul_tag_q[i-1];
            mul_data_q[i] <= mul_data_q[i-1];
        end
    end

    assign alu_wb_valid_o = alu_valid_q;
    assign alu_wb_tag_o   = alu_tag_q;
    assign alu_wb_data_o  = alu_data_q;

    assign mul_wb_valid_o = mul_valid_q[`MUL_STAGES-1];
    assign mul_wb_tag_o   = mul_tag_q[`MUL_STAGES-1];
    assign mul_wb_data_o  = mul_data_q[`MUL_STAGES-1];

endmodule

//--- hw/ooo_core_top.sv
`include "ooo_settings.svh"

module ooo_core_top
    import ooo_pkg::*;
(
    input  logic             clk,
    input  logic             rst,

    input  logic             in_valid_i,
    output logic             in_ready_o,
    input  op_e              in_op_i,
    input  reg_idx_t         in_rd_i,
    input  reg_idx_t         in_rs1_i,
    input  reg_idx_t         in_rs2_i,
    input  logic [`XLEN-1:0] in_imm_i,

    output logic             commit_valid_o,
    output reg_idx_t         commit_rd_o,
    output logic [`XLEN-1:0] commit_data_o
);

    // register file read
    reg_idx_t              rs1_addr;
    reg_idx_t              rs2_addr;
    logic [`XLEN-1:0]      rs1_data;
    logic [`XLEN-1:0]      rs2_data;

    // ROB allocation
    logic                  rob_full;
    logic [`ROB_TAG_W-1:0] rob_tail;
    logic                  enq;
    rob_entry_t            enq_entry;

    // issue
    logic                  issue_valid;
    op_e                   issue_op;
    logic [`XLEN-1:0]      issue_a;
    logic [`XLEN-1:0]      issue_b;
    logic [`ROB_TAG_W-1:0] issue_tag;

    // writeback
    logic                  alu_wb_valid;
    logic [`ROB_TAG_W-1:0] alu_wb_tag;
    logic [`XLEN-1:0]      alu_wb_data;
    logic                  mul_wb_valid;
    logic [`ROB_TAG_W-1:0] mul_wb_tag;
    logic [`XLEN-1:0]      mul_wb_data;

    dispatch_unit i_dispatch (
        .clk            (clk),
        .rst            (rst),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_op_i        (in_op_i),
        .in_rd_i        (in_rd_i),
        .in_rs1_i       (in_rs1_i),
        .in_rs2_i       (in_rs2_i),
        .in_imm_i       (in_imm_i),
        .rs1_addr_o     (rs1_addr),
        .rs2_addr_o     (rs2_addr),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .rob_full_i     (rob_full),
        .rob_tail_i     (rob_tail),
        .enq_o          (enq),
        .enq_entry_o    (enq_entry),
        .issue_valid_o  (issue_valid),
        .issue_op_o     (issue_op),
        .issue_a_o      (issue_a),
        .issue_b_o      (issue_b),
        .issue_tag_o    (issue_tag),
        .commit_valid_i (commit_valid_o),
        .commit_rd_i    (commit_rd_o)
    );

    exec_pipe i_exec (
        .clk            (clk),
        .rst            (rst),
        .issue_valid_i  (issue_valid),
        .issue_op_i     (issue_op),
        .issue_a_i      (issue_a),
        .issue_b_i      (issue_b),
        .issue_tag_i    (issue_tag),
        .alu_wb_valid_o (alu_wb_valid),
        .alu_wb_tag_o   (alu_wb_tag),
        .alu_wb_data_o  (alu_wb_data),
        .mul_wb_valid_o (mul_wb_valid),
        .mul_wb_tag_o   (mul_wb_tag),
        .mul_wb_data_o  (mul_wb_data)
    );

    rob i_rob (
        .clk            (clk),
        .rst            (rst),
        .enq_i          (enq),
        .enq_entry_i    (enq_entry),
        .tail_o         (rob_tail),
        .full_o         (rob_full),
        .alu_wb_valid_i (alu_wb_valid),
        .alu_wb_tag_i   (alu_wb_tag),
        .alu_wb_data_i  (alu_wb_data),
        .mul_wb_valid_i (mul_wb_valid),
        .mul_wb_tag_i   (mul_wb_tag),
        .mul_wb_data_i  (mul_wb_data),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    // the retirement stream is also the register file write port
    arch_regfile i_regfile (
        .clk            (clk),
        .rst            (rst),
        .rs1_addr_i     (rs1_addr),
        .rs2_addr_i     (rs2_addr),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .wr_en_i        (commit_valid_o),
        .wr_addr_i      (commit_rd_o),
        .wr_data_i      (commit_data_o)
    );

endmodule

//--- hw/ooo_pkg.sv
package ooo_pkg;

`include "ooo_settings.svh"

    // register index and data words as they travel between units
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

    // instruction opcodes
    typedef enum logic [1:0] {
        op_addi = 2'd0,
        op_add  = 2'd1,
        op_xor  = 2'd2,
        op_mul  = 2'd3
    } op_e;

    // completion state of a ROB entry
    typedef enum logic {
        st_wait = 1'b0,
        st_done = 1'b1
    } rob_status_e;

    // one ROB slot, 39 bits with the default widths
    typedef struct packed {
        logic                valid;
        rob_status_e         status;
        reg_idx_t            rd;
        logic [`XLEN-1:0]    data;
    } rob_entry_t;

endpackage

//--- hw/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// datapath width
`define XLEN 32

// architectural register file, x0 reads as zero
`define NUM_REGS 32
`define REG_ADDR_W 5

// reorder buffer size, tag width must cover the depth
`define ROB_DEPTH 16
`define ROB_TAG_W 4

// multiplier latency in cycles
`define MUL_STAGES 3

`endif

//--- hw/rob.sv
`include "ooo_settings.svh"

module rob
    import ooo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,

    // allocation from dispatch
    input  logic                  enq_i,
    input  rob_entry_t            enq_entry_i,
    output logic [`ROB_TAG_W-1:0] tail_o,
    output logic                  full_o,

    // ALU writeback
    input  logic                  alu_wb_valid_i,
    input  logic [`ROB_TAG_W-1:0] alu_wb_tag_i,
    input  logic [`XLEN-1:0]      alu_wb_data_i,

    // multiplier writeback
    input  logic                  mul_wb_valid_i,
    input  logic [`ROB_TAG_W-1:0] mul_wb_tag_i,
    input  logic [`XLEN-1:0]      mul_wb_data_i,

    // in-order retirement
    output logic                  commit_valid_o,
    output reg_idx_t              commit_rd_o,
    output logic [`XLEN-1:0]      commit_data_o
);

    rob_entry_t rob_table [`ROB_DEPTH];

    logic [`ROB_TAG_W-1:0] head;
    logic [`ROB_TAG_W-1:0] tail;
    logic [`ROB_TAG_W:0]   count;

    logic enq_fire;
    logic deq_fire;

    assign full_o = (count == `ROB_DEPTH);
    assign tail_o = tail;

    // the head retires as soon as its result is in
    assign commit_valid_o = rob_table[head].valid && (rob_table[head].status == st_done);
    assign commit_rd_o    = rob_table[head].rd;
    assign commit_data_o  = rob_table[head].data;

    assign deq_fire = commit_valid_o;
    // a full table still takes a new entry when the head leaves in the same cycle
    assign enq_fire = enq_i && (!full_o || deq_fire);

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                rob_table[i].valid <= 1'b0;
            end
        end else begin
            // writeback ports never hit the same slot in one cycle
            if (alu_wb_valid_i) begin
                rob_table[alu_wb_tag_i].status <= st_done;
                rob_table[alu_wb_tag_i].data   <= alu_wb_data_i;
            end
            if (mul_wb_valid_i) begin
                rob_table[mul_wb_tag_i].status <= st_done;
                rob_table[mul_wb_tag_i].data   <= mul_wb_data_i;
            end

            // retire before allocate, so a slot reused while full keeps its new valid bit
            if (deq_fire) begin
                rob_table[head].valid <= 1'b0;
                head <= (head == `ROB_DEPTH-1) ? '0 : head + 1'b1;
            end

            if (enq_fire) begin
                rob_table[tail] <= enq_entry_i;
                tail <= (tail == `ROB_DEPTH-1) ? '0 : tail + 1'b1;
            end

            case ({enq_fire, deq_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and judge the result from the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module tb_ooo_core \
    && ./obj_dir/Vtb_ooo_core > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0

//--- testbench/ooo_assertions.sv
`include "ooo_settings.svh"

module ooo_assertions (
    input logic                  clk,
    input logic                  rst,
    input logic [`ROB_TAG_W:0]   count_i,
    input logic                  full_i,
    input logic                  enq_i,
    input logic                  deq_i,
    input logic                  alu_wb_valid_i,
    input logic [`ROB_TAG_W-1:0] alu_wb_tag_i,
    input logic                  alu_entry_valid_i,
    input logic                  mul_wb_valid_i,
    input logic [`ROB_TAG_W-1:0] mul_wb_tag_i,
    input logic                  mul_entry_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // occupancy never goes past the table size
    count_bound: assert property (@(posedge clk) disable iff (rst)
        count_i <= `ROB_DEPTH)
        else $error("ROB count %0d exceeds the depth", count_i);

    // a full table only takes an entry when the head leaves in the same cycle
    enq_when_full: assert property (@(posedge clk) disable iff (rst)
        (enq_i && full_i) |-> deq_i)
        else $error("enqueue into a full ROB without a dequeue");

    distinct_wb_tags: assert property (@(posedge clk) disable iff (rst)
        (alu_wb_valid_i && mul_wb_valid_i) |-> (alu_wb_tag_i != mul_wb_tag_i))
        else $error("both writeback ports target tag %0d", alu_wb_tag_i);

    // results only land in allocated slots
    alu_wb_live: assert property (@(posedge clk) disable iff (rst)
        alu_wb_valid_i |-> alu_entry_valid_i)
        else $error("ALU writeback to empty ROB slot %0d", alu_wb_tag_i);

    mul_wb_live: assert property (@(posedge clk) disable iff (rst)
        mul_wb_valid_i |-> mul_entry_valid_i)
        else $error("multiplier writeback to empty ROB slot %0d", mul_wb_tag_i);

endmodule

bind rob ooo_assertions i_rob_assertions (
    .clk               (clk),
    .rst               (rst),
    .count_i           (count),
    .full_i            (full_o),
    .enq_i             (enq_i),
    .deq_i             (deq_fire),
    .alu_wb_valid_i    (alu_wb_valid_i),
    .alu_wb_tag_i      (alu_wb_tag_i),
    .alu_entry_valid_i (rob_table[alu_wb_tag_i].valid),
    .mul_wb_valid_i    (mul_wb_valid_i),
    .mul_wb_tag_i      (mul_wb_tag_i),
    .mul_entry_valid_i (rob_table[mul_wb_tag_i].valid)
);

//--- testbench/tb_ooo_core.sv
`include "ooo_settings.svh"

module tb_ooo_core
    import ooo_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RANDOM     = 400;
    localparam int TIMEOUT_CYCLES = NUM_RANDOM * 10 + 200;
    localparam int DRAIN_CYCLES   = 100;

    logic             clk;
    logic             rst;
    logic             in_valid_i;
    logic             in_ready_o;
    op_e              in_op_i;
    reg_idx_t         in_rd_i;
    reg_idx_t         in_rs1_i;
    reg_idx_t         in_rs2_i;
    logic [`XLEN-1:0] in_imm_i;
    logic             commit_valid_o;
    reg_idx_t         commit_rd_o;
    logic [`XLEN-1:0] commit_data_o;

    // architectural state in program order
    logic [`XLEN-1:0] model_regs [`NUM_REGS];
    reg_idx_t         exp_rd_q[$];
    logic [`XLEN-1:0] exp_data_q[$];

    logic [31:0] lfsr_state;
    logic        stall_seen;
    int          cycle_count;
    int          accept_count;
    int          commit_count;
    int          mismatch_count;
    int          missing_count;
    int          unexpected_count;
    int          other_count;

    ooo_core_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .in_valid_i     (in_valid_i),
        .in_ready_o     (in_ready_o),
        .in_op_i        (in_op_i),
        .in_rd_i        (in_rd_i),
        .in_rs1_i       (in_rs1_i),
        .in_rs2_i       (in_rs2_i),
        .in_imm_i       (in_imm_i),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_data_o  (commit_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %0b got %0b", $time, what, exp, got);
            mismatch_count++;
        end
    endtask

    task automatic check_rd(input reg_idx_t got, input reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s expected x%0d got x%0d", $time, what, exp, got);
            mismatch_count++;
        end
    endtask

    task automatic check_data(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, what, exp, got);
            mismatch_count++;
        end
    endtask

    function automatic logic [`XLEN-1:0] read_model(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        return model_regs[idx];
    endfunction

    // result at the instruction's place in program order
    task automatic model_accept(input op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                                input reg_idx_t rs2, input logic [`XLEN-1:0] imm);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] result;
        a = read_model(rs1);
        b = (op == op_addi) ? imm : read_model(rs2);
        case (op)
            op_xor:  result = a ^ b;
            op_mul:  result = a * b;
            default: result = a + b;
        endcase
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(result);
        if (rd != '0) begin
            model_regs[rd] = result;
        end
        accept_count++;
    endtask

    // starts and ends on a falling edge and holds the instruction until accepted
    task automatic send_instr(input op_e op, input reg_idx_t rd, input reg_idx_t rs1,
                              input reg_idx_t rs2, input logic [`XLEN-1:0] imm);
        logic ready;
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_rd_i    = rd;
        in_rs1_i   = rs1;
        in_rs2_i   = rs2;
        in_imm_i   = imm;
        ready      = 1'b0;
        while (!ready) begin
            #1;
            ready = in_ready_o;
            if (!ready) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            if (!ready) begin
                @(negedge clk);
            end
        end
        model_accept(op, rd, rs1, rs2, imm);
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    task automatic run_random(input int n);
        logic [31:0]      r;
        op_e              op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [`XLEN-1:0] imm;
        for (int k = 0; k < n; k++) begin
            draw_bits(2, r);
            op = op_e'(r[1:0]);
            draw_bits(5, r);
            rd = r[4:0];
            draw_bits(5, r);
            rs1 = r[4:0];
            draw_bits(5, r);
            rs2 = r[4:0];
            draw_bits(`XLEN, r);
            imm = r;
            send_instr(op, rd, rs1, rs2, imm);
        end
    endtask

    task automatic mul_burst();
        for (int i = 0; i < `ROB_DEPTH + 4; i++) begin
            // rs2 names the previous multiply's destination
            send_instr(op_mul, reg_idx_t'(i + 1), reg_idx_t'(21 + i % 8), reg_idx_t'(i), '0);
        end
    endtask

    // retirement is sampled mid-cycle before the edge that performs it
    always @(negedge clk) begin
        if (!rst && commit_valid_o) begin
            commit_count++;
            if (exp_rd_q.size() == 0) begin
                $display("unexpected commit at %0t of x%0d with nothing outstanding",
                         $time, commit_rd_o);
                unexpected_count++;
            end else begin
                check_rd(commit_rd_o, exp_rd_q.pop_front(),
                         $sformatf("commit %0d rd", commit_count));
                check_data(commit_data_o, exp_data_q.pop_front(),
                           $sformatf("commit %0d data", commit_count));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles with %0d commits still outstanding",
                     cycle_count, exp_rd_q.size());
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        in_valid_i = 1'b0;
        in_op_i    = op_addi;
        in_rd_i    = '0;
        in_rs1_i   = '0;
        in_rs2_i   = '0;
        in_imm_i   = '0;
        lfsr_state = 32'h5ef;
        stall_seen = 1'b0;
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        check_flag(commit_valid_o, 1'b0, "commit_valid_o after reset");
        check_flag(in_ready_o, 1'b1, "in_ready_o after reset");
        @(negedge clk);

        run_random(NUM_RANDOM);

        // the multiply finishes last but retires ahead of the younger addi ops
        send_instr(op_addi, 5'd1, 5'd0, 5'd0, 32'd7);
        send_instr(op_addi, 5'd2, 5'd0, 5'd0, 32'h1234);
        send_instr(op_mul, 5'd3, 5'd1, 5'd2, '0);
        for (int i = 0; i < 4; i++) begin
            send_instr(op_addi, reg_idx_t'(4 + i), 5'd0, 5'd0, 32'(100 + i));
        end

        // each source is the previous destination
        send_instr(op_addi, 5'd5, 5'd0, 5'd0, 32'd3);
        send_instr(op_add, 5'd6, 5'd5, 5'd5, '0);
        send_instr(op_mul, 5'd7, 5'd6, 5'd6, '0);
        send_instr(op_xor, 5'd8, 5'd7, 5'd6, '0);
        send_instr(op_addi, 5'd8, 5'd8, 5'd0, 32'hffff_fff0);
        send_instr(op_add, 5'd5, 5'd8, 5'd7, '0);

        // x0 writes retire with data but later reads stay zero
        send_instr(op_addi, 5'd0, 5'd0, 5'd0, 32'h55);
        send_instr(op_xor, 5'd0, 5'd5, 5'd6, '0);
        send_instr(op_add, 5'd9, 5'd0, 5'd0, '0);
        send_instr(op_addi, 5'd10, 5'd0, 5'd0, 32'd1);
        send_instr(op_add, 5'd11, 5'd0, 5'd10, '0);

        stall_seen = 1'b0;
        mul_burst();
        if (!stall_seen) begin
            $display("in_ready_o never went low during the multiply burst");
            other_count++;
        end

        // give the last instructions a bounded time to retire
        for (int w = 0; w < DRAIN_CYCLES; w++) begin
            if (exp_rd_q.size() == 0) begin
                break;
            end
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        missing_count = exp_rd_q.size();
        if (missing_count != 0) begin
            $display("%0d accepted instructions never committed", missing_count);
        end
        if (commit_count != accept_count) begin
            $display("%0d commits seen for %0d accepted instructions",
                     commit_count, accept_count);
            other_count++;
        end
        $display("errors: %0d mismatches, %0d missing commits, %0d unexpected commits, %0d other",
                 mismatch_count, missing_count, unexpected_count, other_count);
        if (mismatch_count + missing_count + unexpected_count + other_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
